//--- alut.f
hdl/alut_pkg.sv
hdl/alut_mem.sv
hdl/alut_age_checker.sv
hdl/alut_addr_checker.sv
hdl/alut_top.sv
dv/alut_tb.sv

//--- dv/alut_tb.sv
`timescale 1ns/1ps

module alut_tb;

   import alut_pkg::*;

   localparam alut_time_t  max_age      = 32'd100;
   localparam logic [31:0] fresh_cycles = 32'd40;    // lookups this young are in date
   localparam logic [31:0] stale_cycles = 32'd400;   // this old is always stale
   localparam int          pairs        = 8;         // learn/lookup pairs in the hit test

   // one mirrored table slot
   typedef struct packed {
      logic        valid;
      logic [31:0] stamp;      // tb cycle at learning
      port_t       port;
      mac_addr_t   addr;
   } mirror_t;

   // reference answer for one lookup
   typedef struct packed {
      port_mask_t d_port;
      logic       evict;
      mac_addr_t  inv_addr;
      port_t      inv_port;
      logic [3:0] cycles;      // add_check_active length
   } predict_t;

   // expected dut outputs at a compare
   typedef struct packed {
      port_mask_t d_port;
      logic       active;
      logic       reused;
      mac_addr_t  inv_addr;
      port_t      inv_port;
   } expect_t;

   logic        pclk19;
   logic        n_p_reset19;
   cmd_t        command;
   mac_addr_t   mac_addr;        // the switch's own address
   mac_addr_t   d_addr;
   mac_addr_t   s_addr;
   port_t       s_port;
   logic        clear_reused;
   port_mask_t  d_port;
   logic        add_check_active;
   logic        reused;
   mac_addr_t   lst_inv_addr;
   port_t       lst_inv_port;

   mirror_t     mirror [table_depth];
   expect_t     want;                  // read by the compare process
   logic [31:0] cycle_cnt = '0;        // tb time base
   logic [31:0] lcg_state;
   string       cur_test;
   int          errors;
   int          checks;
   int          tests;
   int          test_errors;
   mac_addr_t   learned_addr [pairs];
   port_t       learned_port [pairs];
   event        compare_ev;
   event        abort_ev;

   alut_top #(.max_age (max_age)) i_alut_top
   (
      .pclk19           (pclk19),
      .n_p_reset19      (n_p_reset19),
      .command          (command),
      .mac_addr         (mac_addr),
      .d_addr           (d_addr),
      .s_addr           (s_addr),
      .s_port           (s_port),
      .clear_reused     (clear_reused),
      .d_port           (d_port),
      .add_check_active (add_check_active),
      .reused           (reused),
      .lst_inv_addr     (lst_inv_addr),
      .lst_inv_port     (lst_inv_port)
   );

   always #10 pclk19 = ~pclk19;   // 20 ns period

   always @(posedge pclk19)
      cycle_cnt <= cycle_cnt + 32'd1;

   // ------------------------------
   // helpers and reference model
   // ------------------------------
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic port_t rand_port();
      logic [31:0] r;
      r = lcg_next();
      return r[31:30];   // upper bits are the most random
   endfunction

   // table index is the xor of the six address bytes
   function automatic hash_t mac_hash(input mac_addr_t a);
      hash_t h;
      h = '0;
      for (int i = 0; i < 6; i++)
         h ^= a[8*i +: 8];
      return h;
   endfunction

   function automatic port_mask_t one_hot(input port_t p);
      port_mask_t m;
      case (p)
         2'd0:    m = 5'b0_0001;
         2'd1:    m = 5'b0_0010;
         2'd2:    m = 5'b0_0100;
         default: m = 5'b0_1000;
      endcase
      return m;
   endfunction

   // random address whose slot is still empty in the mirror
   function automatic mac_addr_t free_addr();
      mac_addr_t   a;
      logic [31:0] hi;
      logic [31:0] lo;
      a = '0;
      for (int tries = 0; tries < 1000; tries++)
      begin
         hi = lcg_next();
         lo = lcg_next();
         a  = {hi[15:0], lo};
         if (!mirror[mac_hash(a)].valid && a != mac_addr)
            return a;
      end
      return a;
   endfunction

   function automatic predict_t predict(input mac_addr_t d, input mac_addr_t s,
                                        input port_t sp, input logic [31:0] now);
      predict_t e;
      mirror_t  dst;
      mirror_t  vic;
      e = '0;
      if (d == mac_addr)
      begin
         e.d_port = 5'b1_0000;   // for the switch and nothing learned
         e.cycles = 4'd1;
         return e;
      end
      dst = mirror[mac_hash(d)];
      e.cycles = dst.valid ? 4'd9 : 4'd5;   // empty slot skips the age check
      if (dst.valid && dst.addr == d && (now - dst.stamp) <= fresh_cycles)
         e.d_port = one_hot(dst.port) & ~one_hot(sp);
      else
         e.d_port = 5'b0_1111 & ~one_hot(sp);          // miss floods
      vic = mirror[mac_hash(s)];
      if (vic.valid && vic.addr != s)
      begin
         e.evict    = 1'b1;
         e.inv_addr = vic.addr;
         e.inv_port = vic.port;
      end
      return e;
   endfunction

   // ------------------------------
   // checking and bookkeeping
   // ------------------------------
   task automatic check_value(input string what, input logic [63:0] exp,
                              input logic [63:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         test_errors++;
         $display("FAILED %s, %s: expected %0h, actual %0h", cur_test, what, exp, act);
      end
   endtask

   always @(compare_ev)
   begin
      check_value("d_port", 64'(want.d_port), 64'(d_port));
      check_value("add_check_active", 64'(want.active), 64'(add_check_active));
      check_value("reused", 64'(want.reused), 64'(reused));
      check_value("lst_inv_addr", 64'(want.inv_addr), 64'(lst_inv_addr));
      check_value("lst_inv_port", 64'(want.inv_port), 64'(lst_inv_port));
   end

   always @(abort_ev)
   begin
      $display("Something failed");
      $finish;
   end

   task automatic begin_test(input string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic report_test();
      @(posedge pclk19);   // let a pending compare finish
      tests++;
      if (test_errors == 0)
         $display("test %s: passed", cur_test);
      else
         $display("test %s: %0d errors", cur_test, test_errors);
   endtask

   // ------------------------------
   // stimulus
   // ------------------------------
   task automatic wait_check_done(output int cycles);
      int n;
      @(negedge pclk19);
      n = 0;
      if (!add_check_active)
      begin
         errors++;
         test_errors++;
         $display("add_check_active did not rise after the command in %s", cur_test);
      end
      while (add_check_active && n < 50)
      begin
         n++;                 // one more cycle seen active
         @(negedge pclk19);
      end
      if (add_check_active)
      begin
         errors++;
         $display("timeout, add_check_active still high after 50 cycles in %s", cur_test);
         -> abort_ev;
      end
      cycles = n;
   endtask

   task automatic lookup(input mac_addr_t d, input mac_addr_t s, input port_t sp);
      predict_t    p;
      logic [31:0] age;
      int          n;
      @(posedge pclk19);
      #2;
      d_addr  = d;
      s_addr  = s;
      s_port  = sp;
      command = cmd_check;
      age = cycle_cnt - mirror[mac_hash(d)].stamp;
      if (d != mac_addr && mirror[mac_hash(d)].valid && mirror[mac_hash(d)].addr == d
          && age > fresh_cycles && age < stale_cycles)
      begin
         errors++;
         test_errors++;
         $display("lookup of %h falls between the in-date and stale zones", d);
      end
      p = predict(d, s, sp, cycle_cnt);
      want.d_port = p.d_port;
      if (p.evict)
      begin
         want.reused   = 1'b1;   // sticky
         want.inv_addr = p.inv_addr;
         want.inv_port = p.inv_port;
      end
      if (d != mac_addr)
         mirror[mac_hash(s)] = '{valid: 1'b1, stamp: cycle_cnt, port: sp, addr: s};
      @(posedge pclk19);
      #2 command = '0;   // one cycle pulse
      wait_check_done(n);
      check_value("active cycles", 64'(p.cycles), 64'(n));
      -> compare_ev;
   endtask

   task automatic pulse_clear();
      @(posedge pclk19);
      #2 clear_reused = 1'b1;
      @(posedge pclk19);
      #2 clear_reused = 1'b0;
      want.reused = 1'b0;   // address and port stay
      @(negedge pclk19);
      -> compare_ev;
   endtask

   initial
   begin
      mac_addr_t src;
      port_t     sp;
      pclk19       = 1'b0;
      n_p_reset19  = 1'b0;
      command      = '0;
      mac_addr     = 48'h02_00_5e_10_20_30;
      d_addr       = '0;
      s_addr       = '0;
      s_port       = '0;
      clear_reused = 1'b0;
      lcg_state    = 32'h52ce73e2;
      errors       = 0;
      checks       = 0;
      tests        = 0;
      foreach (mirror[k])
         mirror[k] = '0;
      want = '{d_port: 5'b0_1111, active: 1'b0, reused: 1'b0, inv_addr: '0, inv_port: '0};
      repeat (5) @(posedge pclk19);
      #2 n_p_reset19 = 1'b1;

      begin_test("reset state");
      @(negedge pclk19);
      -> compare_ev;
      report_test();

      begin_test("switch address");
      src = free_addr();
      sp  = rand_port();
      lookup(mac_addr, src, sp);             // not learned
      lookup(src, free_addr(), sp + 2'd1);   // so this floods
      report_test();

      begin_test("learn and hit");
      for (int i = 0; i < pairs; i++)
      begin
         learned_addr[i] = free_addr();
         learned_port[i] = rand_port();
         lookup(free_addr(), learned_addr[i], learned_port[i]);  // unknown dest
         sp = (i == 0) ? learned_port[i] : rand_port();           // first one masks to 0
         lookup(learned_addr[i], free_addr(), sp);
      end
      report_test();

      begin_test("aged out");
      repeat (stale_cycles) @(posedge pclk19);
      lookup(learned_addr[0], learned_addr[1], learned_port[1]);  // stale and relearns 1
      lookup(learned_addr[1], learned_addr[0], learned_port[0]);  // in date again
      report_test();

      begin_test("reused entry");
      src = learned_addr[2] ^ 48'h0000_0000_a5a5;   // bytes 0 and 1 flipped alike
      lookup(free_addr(), src, learned_port[2] + 2'd1);
      pulse_clear();
      lookup(free_addr(), src, learned_port[2] + 2'd1);   // same address so no eviction
      report_test();

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

//--- hdl/alut_addr_checker.sv
`timescale 1ns/1ps

module alut_addr_checker
(
   input  logic                 pclk19,
   input  logic                 n_p_reset19,
   input  alut_pkg::cmd_t       command,          // sampled in idle only
   input  alut_pkg::mac_addr_t  mac_addr,         // the switch's own address
   input  alut_pkg::mac_addr_t  d_addr,           // destination of the frame
   input  alut_pkg::mac_addr_t  s_addr,           // source of the frame, to learn
   input  alut_pkg::port_t      s_port,           // port the frame came in on
   input  alut_pkg::alut_time_t curr_time,        // stamp for learned entries
   input  alut_pkg::alut_entry_t rd_data,         // registered table read data
   input  alut_pkg::age_rsp_t   age_rsp,
   input  logic                 clear_reused,
   output alut_pkg::mem_req_t   mem_req,
   output alut_pkg::age_req_t   age_req,
   output alut_pkg::port_mask_t d_port,           // where to send the frame
   output logic                 add_check_active,
   output logic                 reused,           // sticky eviction flag
   output alut_pkg::mac_addr_t  lst_inv_addr,     // last evicted address
   output alut_pkg::port_t      lst_inv_port      // and its port
);

   import alut_pkg::*;

   chk_state_t state_q;       // current checker state
   chk_state_t state_d;
   hash_t      s_hash;        // table slot for learning
   hash_t      d_hash;        // table slot for lookup
   logic       dst_is_switch; // frame addressed to the switch itself
   logic       addr_hit;      // stored address equals destination
   logic       evict;         // write would replace another address
   logic       check_age_q;   // age request pulse
   logic       in_date_q;     // age result latched on confirm
   port_mask_t src_mask;      // one-hot of the source port
   port_mask_t stored_mask;   // one-hot of the stored port

   // ------------------------------
   // hashing and compares
   // ------------------------------
   function automatic hash_t addr_hash(input mac_addr_t a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ a[47:40];
   endfunction

   assign s_hash        = addr_hash(s_addr);
   assign d_hash        = addr_hash(d_addr);
   assign dst_is_switch = (d_addr == mac_addr);
   assign addr_hit      = (rd_data.addr == d_addr);
   assign evict         = rd_data.valid && (rd_data.addr != s_addr); // rd_data is victim here
   assign src_mask      = port_mask_t'(5'b0_0001 << s_port);
   assign stored_mask   = port_mask_t'(5'b0_0001 << rd_data.port);

   assign add_check_active = (state_q != idle);

   // ------------------------------
   // lookup / learn fsm
   // ------------------------------
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         idle:
            if (command == cmd_check)
               state_d = mac_addr_chk;
         mac_addr_chk:
            state_d = dst_is_switch ? idle : read_dest; // no learning for switch frames
         read_dest:
            state_d = valid_chk;      // dest entry arrives next cycle
         valid_chk:
            state_d = rd_data.valid ? age_chk : read_src; // empty slot, skip the checks
         age_chk:
            if (age_rsp.confirmed)
               state_d = addr_chk;
         addr_chk:
            state_d = read_src;
         read_src:
            state_d = write_src;      // victim entry arrives next cycle
         write_src:
            state_d = idle;
         default:
            state_d = idle;
      endcase
   end

   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
         state_q <= idle;
      else
         state_q <= state_d;
   end

   // ------------------------------
   // table requests
   // ------------------------------
   always_comb
   begin
      mem_req       = '0;
      mem_req.addr  = d_hash;         // lookup slot unless learning
      mem_req.wdata = '{valid: 1'b1, last_time: curr_time, port: s_port, addr: s_addr};
      case (state_q)
         read_dest:
            mem_req.read = 1'b1;
         read_src:
         begin
            mem_req.read = 1'b1;      // fetch what is about to be replaced
            mem_req.addr = s_hash;
         end
         write_src:
         begin
            mem_req.write = 1'b1;
            mem_req.addr  = s_hash;
         end
         default:
            mem_req.read = 1'b0;
      endcase
   end

   // ------------------------------
   // age check handshake
   // ------------------------------
   // pulse in the 2nd age_chk cycle, confirm lands in the 3rd
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
      begin
         check_age_q <= 1'b0;
         in_date_q   <= 1'b0;
      end
      else
      begin
         check_age_q <= (state_q == age_chk) && !check_age_q && !age_rsp.confirmed;
         if ((state_q == age_chk) && age_rsp.confirmed)
            in_date_q <= age_rsp.ok;  // held for addr_chk
      end
   end

   assign age_req.check_age     = check_age_q;
   assign age_req.last_accessed = rd_data.last_time;  // dest entry stays on rd_data

   // ------------------------------
   // destination port
   // ------------------------------
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
         d_port <= flood_all;
      else
      begin
         case (state_q)
            mac_addr_chk:
               if (dst_is_switch)
                  d_port <= switch_port;
            valid_chk:
               if (!rd_data.valid)
                  d_port <= flood_all & ~src_mask;   // unknown, flood
            addr_chk:
               if (in_date_q && addr_hit)
                  d_port <= stored_mask & ~src_mask; // may end up empty
               else
                  d_port <= flood_all & ~src_mask;   // stale or other address
            default:
               d_port <= d_port;
         endcase
      end
   end

   // ------------------------------
   // eviction tracking
   // ------------------------------
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
      begin
         reused       <= 1'b0;
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if ((state_q == write_src) && evict)
      begin
         reused       <= 1'b1;         // set wins over clear
         lst_inv_addr <= rd_data.addr;
         lst_inv_port <= rd_data.port;
      end
      else if (clear_reused)
         reused <= 1'b0;               // address and port are kept
   end

endmodule

//--- hdl/alut_age_checker.sv
`timescale 1ns/1ps

module alut_age_checker
#(
   parameter alut_pkg::alut_time_t max_age = 32'd1000  // oldest in-date age, cycles
)
(
   input  logic                 pclk19,
   input  logic                 n_p_reset19,
   input  alut_pkg::age_req_t   age_req,
   output alut_pkg::age_rsp_t   age_rsp,
   output alut_pkg::alut_time_t curr_time    // switch time
);

   import alut_pkg::*;

   alut_time_t age_diff;   // elapsed time since the entry was stamped

   // ------------------------------
   // switch time
   // ------------------------------
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
         curr_time <= '0;
      else
         curr_time <= curr_time + 1'b1;  // wraps, difference stays right
   end

   assign age_diff = curr_time - age_req.last_accessed;  // modulo 2^32

   // ------------------------------
   // in-date judgment
   // ------------------------------
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
      begin
         age_rsp.confirmed <= 1'b0;
         age_rsp.ok        <= 1'b0;
      end
      else
      begin
         age_rsp.confirmed <= age_req.check_age;  // answer exactly one cycle later
         if (age_req.check_age)
            age_rsp.ok <= (age_diff <= max_age);
      end
   end

endmodule

//--- hdl/alut_mem.sv
`timescale 1ns/1ps

module alut_mem
(
   input  logic                  pclk19,
   input  logic                  n_p_reset19,
   input  alut_pkg::mem_req_t    mem_req,
   output alut_pkg::alut_entry_t rd_data    // held until the next read
);

   import alut_pkg::*;

   localparam int payload_w = $bits(alut_entry_t) - 1;  // entry minus valid bit

   logic [table_depth-1:0] valid_q;                 // cleared at reset
   logic [payload_w-1:0]   payload_q [table_depth]; // time, port, address

   // valid bits, all entries invalid out of reset
   always_ff @(posedge pclk19 or negedge n_p_reset19)
   begin
      if (!n_p_reset19)
         valid_q <= '0;
      else if (mem_req.write)
         valid_q[mem_req.addr] <= mem_req.wdata.valid;
   end

   // payload array and read register
   always_ff @(posedge pclk19)
   begin
      if (mem_req.write)
         payload_q[mem_req.addr] <= mem_req.wdata[payload_w-1:0];
      if (mem_req.read)
         rd_data <= {valid_q[mem_req.addr], payload_q[mem_req.addr]}; // old data on collision
   end

endmodule

//--- hdl/alut_pkg.sv
package alut_pkg;

   // ------------------------------
   // table geometry
   // ------------------------------
   localparam int hash_w      = 8;             // xor of the six address bytes
   localparam int table_depth = 1 << hash_w;   // one entry per hash value

   typedef logic [47:0]       mac_addr_t;      // ethernet mac address
   typedef logic [1:0]        port_t;          // ethernet port number
   typedef logic [4:0]        port_mask_t;     // bit 4 = switch, 3:0 = ports
   typedef logic [hash_w-1:0] hash_t;          // table index
   typedef logic [31:0]       alut_time_t;     // time in pclk cycles
   typedef logic [1:0]        cmd_t;           // software command code

   localparam cmd_t       cmd_check   = 2'd1;      // check and learn
   localparam port_mask_t flood_all   = 5'b0_1111; // every ethernet port
   localparam port_mask_t switch_port = 5'b1_0000; // frame is for the switch

   // one table entry, msb first
   typedef struct packed {
      logic       valid;
      alut_time_t last_time;   // stamp taken when learned
      port_t      port;
      mac_addr_t  addr;
   } alut_entry_t;

   typedef struct packed {
      logic        read;       // registered read, data next cycle
      logic        write;      // write at the clock edge
      hash_t       addr;
      alut_entry_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic       check_age;       // single cycle request
      alut_time_t last_accessed;   // stamp of the entry being judged
   } age_req_t;

   typedef struct packed {
      logic confirmed;   // single cycle, one cycle after check_age
      logic ok;          // entry in date, valid with confirmed
   } age_rsp_t;

   typedef enum logic [2:0] {
      idle, mac_addr_chk, read_dest, valid_chk, age_chk, addr_chk, read_src, write_src
   } chk_state_t;

endpackage

//--- hdl/alut_top.sv
`timescale 1ns/1ps

module alut_top
#(
   parameter alut_pkg::alut_time_t max_age = 32'd1000  // entry lifetime in cycles
)
(
   input  logic                 pclk19,
   input  logic                 n_p_reset19,
   input  alut_pkg::cmd_t       command,
   input  alut_pkg::mac_addr_t  mac_addr,
   input  alut_pkg::mac_addr_t  d_addr,
   input  alut_pkg::mac_addr_t  s_addr,
   input  alut_pkg::port_t      s_port,
   input  logic                 clear_reused,
   output alut_pkg::port_mask_t d_port,
   output logic                 add_check_active,
   output logic                 reused,
   output alut_pkg::mac_addr_t  lst_inv_addr,
   output alut_pkg::port_t      lst_inv_port
);

   import alut_pkg::*;

   // ------------------------------
   // internal links
   // ------------------------------
   mem_req_t    mem_req;    // checker -> table
   alut_entry_t rd_data;    // table -> checker
   age_req_t    age_req;    // checker -> age checker
   age_rsp_t    age_rsp;    // age checker -> checker
   alut_time_t  curr_time;  // stamp for new entries

   // lookup and learning
   alut_addr_checker i_addr_checker
   (
      .pclk19           (pclk19),
      .n_p_reset19      (n_p_reset19),
      .command          (command),
      .mac_addr         (mac_addr),
      .d_addr           (d_addr),
      .s_addr           (s_addr),
      .s_port           (s_port),
      .curr_time        (curr_time),
      .rd_data          (rd_data),
      .age_rsp          (age_rsp),
      .clear_reused     (clear_reused),
      .mem_req          (mem_req),
      .age_req          (age_req),
      .d_port           (d_port),
      .add_check_active (add_check_active),
      .reused           (reused),
      .lst_inv_addr     (lst_inv_addr),
      .lst_inv_port     (lst_inv_port)
   );

   // time keeping
   alut_age_checker
   #(
      .max_age (max_age)
   )
   i_age_checker
   (
      .pclk19      (pclk19),
      .n_p_reset19 (n_p_reset19),
      .age_req     (age_req),
      .age_rsp     (age_rsp),
      .curr_time   (curr_time)
   );

   // address table
   alut_mem i_mem
   (
      .pclk19      (pclk19),
      .n_p_reset19 (n_p_reset19),
      .mem_req     (mem_req),
      .rd_data     (rd_data)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the alut testbench with verilator, run it, judge by the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module alut_tb -f alut.f -o alut_sim \
   || { echo "build failed"; exit 1; }

out=$(./obj_dir/alut_sim)
echo "$out"
echo "$out" | grep -qx "Everything OK" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
